// File: verilog/cr16_pkg.sv
`default_nettype none

package cr16_pkg;

	localparam int DATA_W = 16;
	localparam int NUM_REGS = 16;

	// opcode is {instr[15:12], instr[7:4]}
	// immediate forms only use the upper nibble, low nibble kept at zero here
	typedef enum logic [7:0] {
		op_and   = 8'b0000_0001,
		op_or    = 8'b0000_0010,
		op_xor   = 8'b0000_0011,
		op_add   = 8'b0000_0101,
		op_sub   = 8'b0000_1001,
		op_cmp   = 8'b0000_1011,
		op_mov   = 8'b0000_1101,
		op_mul   = 8'b0000_1110,
		op_load  = 8'b0100_0000,
		op_store = 8'b0100_0100,
		op_lsh   = 8'b1000_0100,
		op_ashu  = 8'b1000_0110,
		op_andi  = 8'b0001_0000,
		op_ori   = 8'b0010_0000,
		op_xori  = 8'b0011_0000,
		op_addi  = 8'b0101_0000,
		op_lshi  = 8'b1000_0000,
		op_subi  = 8'b1001_0000,
		op_cmpi  = 8'b1011_0000,
		op_movi  = 8'b1101_0000,
		op_muli  = 8'b1110_0000,
		op_lui   = 8'b1111_0000
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_mul,
		alu_and,
		alu_or,
		alu_xor,
		alu_mov,
		alu_lsh,
		alu_ashu,
		alu_cmp
	} alu_op_e;

	typedef enum logic [1:0] {
		kind_alu     = 2'b00,
		kind_store   = 2'b01,
		kind_load    = 2'b10,
		kind_illegal = 2'b11
	} instr_kind_e;

	typedef struct packed {
		alu_op_e alu_op;
		instr_kind_e kind;
		logic use_imm;
		logic [$clog2(NUM_REGS)-1:0] rd;
		logic [$clog2(NUM_REGS)-1:0] rs;
		logic [DATA_W-1:0] imm;
	} decoded_t;

	typedef struct packed {
		logic z;
		logic l;
		logic n;
	} flags_t;

	// addr is the zero-extended word address, zero for alu and illegal
	typedef struct packed {
		logic valid;
		instr_kind_e kind;
		logic [$clog2(NUM_REGS)-1:0] rd;
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] addr;
	} retire_t;

endpackage

`default_nettype wire

// File: verilog/instr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module instr_decoder (
	input wire [15:0] instr,
	output cr16_pkg::decoded_t dec
);

	cr16_pkg::opcode_e op;
	cr16_pkg::opcode_e op_imm;
	logic [7:0] imm8;
	logic [cr16_pkg::DATA_W-1:0] imm_sext;
	logic [cr16_pkg::DATA_W-1:0] imm_zext;

	assign op = cr16_pkg::opcode_e'({instr[15:12], instr[7:4]});
	// immediate forms are matched on the upper nibble alone
	assign op_imm = cr16_pkg::opcode_e'({instr[15:12], 4'h0});

	assign imm8 = {instr[7:4], instr[3:0]};
	assign imm_sext = {{(cr16_pkg::DATA_W-8){imm8[7]}}, imm8};
	assign imm_zext = {{(cr16_pkg::DATA_W-8){1'b0}}, imm8};

	always_comb
	begin
		dec.rd = instr[11:8];
		dec.rs = instr[3:0];
		dec.kind = cr16_pkg::kind_alu;
		dec.alu_op = cr16_pkg::alu_add;
		dec.use_imm = 1'b0;
		dec.imm = '0;

		case (op)
			cr16_pkg::op_add: dec.alu_op = cr16_pkg::alu_add;
			cr16_pkg::op_sub: dec.alu_op = cr16_pkg::alu_sub;
			cr16_pkg::op_mul: dec.alu_op = cr16_pkg::alu_mul;
			cr16_pkg::op_and: dec.alu_op = cr16_pkg::alu_and;
			cr16_pkg::op_or: dec.alu_op = cr16_pkg::alu_or;
			cr16_pkg::op_xor: dec.alu_op = cr16_pkg::alu_xor;
			cr16_pkg::op_mov: dec.alu_op = cr16_pkg::alu_mov;
			cr16_pkg::op_cmp: dec.alu_op = cr16_pkg::alu_cmp;
			cr16_pkg::op_lsh: dec.alu_op = cr16_pkg::alu_lsh;
			cr16_pkg::op_ashu: dec.alu_op = cr16_pkg::alu_ashu;
			cr16_pkg::op_load: dec.kind = cr16_pkg::kind_load;
			cr16_pkg::op_store: dec.kind = cr16_pkg::kind_store;
			default:
			begin
				dec.use_imm = 1'b1;
				case (op_imm)
					cr16_pkg::op_addi:
					begin
						dec.alu_op = cr16_pkg::alu_add;
						dec.imm = imm_sext;
					end
					cr16_pkg::op_subi:
					begin
						dec.alu_op = cr16_pkg::alu_sub;
						dec.imm = imm_sext;
					end
					cr16_pkg::op_muli:
					begin
						dec.alu_op = cr16_pkg::alu_mul;
						dec.imm = imm_sext;
					end
					cr16_pkg::op_cmpi:
					begin
						dec.alu_op = cr16_pkg::alu_cmp;
						dec.imm = imm_sext;
					end
					cr16_pkg::op_andi:
					begin
						dec.alu_op = cr16_pkg::alu_and;
						dec.imm = imm_zext;
					end
					cr16_pkg::op_ori:
					begin
						dec.alu_op = cr16_pkg::alu_or;
						dec.imm = imm_zext;
					end
					cr16_pkg::op_xori:
					begin
						dec.alu_op = cr16_pkg::alu_xor;
						dec.imm = imm_zext;
					end
					cr16_pkg::op_movi:
					begin
						dec.alu_op = cr16_pkg::alu_mov;
						dec.imm = imm_zext;
					end
					// lshi and lui land here too, they are not implemented
					default:
					begin
						dec.kind = cr16_pkg::kind_illegal;
						dec.use_imm = 1'b0;
					end
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input wire clk,
	input wire rst_n,
	input wire we,
	input wire [$clog2(cr16_pkg::NUM_REGS)-1:0] waddr,
	input wire [cr16_pkg::DATA_W-1:0] wdata,
	input wire [$clog2(cr16_pkg::NUM_REGS)-1:0] ra_a,
	input wire [$clog2(cr16_pkg::NUM_REGS)-1:0] ra_b,
	output logic [cr16_pkg::DATA_W-1:0] rd_a,
	output logic [cr16_pkg::DATA_W-1:0] rd_b
);

	logic [cr16_pkg::DATA_W-1:0] regs [cr16_pkg::NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < cr16_pkg::NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we)
		begin
			regs[waddr] <= wdata;
		end
	end

	// reads see the old value until the write edge
	assign rd_a = regs[ra_a];
	assign rd_b = regs[ra_b];

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
	input wire cr16_pkg::alu_op_e op,
	input wire [cr16_pkg::DATA_W-1:0] a,
	input wire [cr16_pkg::DATA_W-1:0] b,
	output logic [cr16_pkg::DATA_W-1:0] result,
	output cr16_pkg::flags_t flags
);

	localparam int W = cr16_pkg::DATA_W;

	logic signed [W-1:0] a_s;
	logic sh_right;
	logic [4:0] sh_amt;
	logic [W-1:0] shl;
	logic [W-1:0] shr_log;
	logic [W-1:0] shr_ari;
	logic [W-1:0] lsh_res;
	logic [W-1:0] ashu_res;

	assign a_s = a;

	// b[4:0] is a signed shift count and a negative count shifts right
	assign sh_right = b[4];
	assign sh_amt = sh_right ? (~b[4:0] + 5'd1) : b[4:0];

	assign shl = a << sh_amt;
	assign shr_log = a >> sh_amt;
	// arithmetic right shift fills with the sign of a
	assign shr_ari = a_s >>> sh_amt;

	assign lsh_res = sh_right ? shr_log : shl;
	assign ashu_res = sh_right ? shr_ari : shl;

	always_comb
	begin
		case (op)
			cr16_pkg::alu_add: result = a + b;
			cr16_pkg::alu_sub: result = a - b;
			cr16_pkg::alu_mul: result = a * b;
			cr16_pkg::alu_and: result = a & b;
			cr16_pkg::alu_or: result = a | b;
			cr16_pkg::alu_xor: result = a ^ b;
			cr16_pkg::alu_mov: result = b;
			cr16_pkg::alu_lsh: result = lsh_res;
			cr16_pkg::alu_ashu: result = ashu_res;
			cr16_pkg::alu_cmp: result = a;
			default: result = a;
		endcase
	end

	// flags come out for every op and the core latches them on cmp only
	always_comb
	begin
		flags.z = (a == b);
		flags.l = (a < b);
		flags.n = (a_s < $signed(b));
	end

endmodule

`default_nettype wire

// File: verilog/data_mem.sv
`timescale 1ns/10ps
`default_nettype none

module data_mem #(
	parameter int DMEM_WORDS = 64
) (
	input wire clk,
	input wire rst_n,
	input wire we,
	input wire [$clog2(DMEM_WORDS)-1:0] addr,
	input wire [cr16_pkg::DATA_W-1:0] wdata,
	output logic [cr16_pkg::DATA_W-1:0] rdata
);

	logic [cr16_pkg::DATA_W-1:0] mem [DMEM_WORDS];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				mem[i] <= '0;
		end
		else if (we)
		begin
			mem[addr] <= wdata;
		end
	end

	assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: verilog/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core #(
	parameter int DMEM_WORDS = 64
) (
	input wire clk,
	input wire rst_n,
	input wire instr_valid,
	input wire [15:0] instr,
	output cr16_pkg::retire_t ret,
	output cr16_pkg::flags_t flags
);

	localparam int W = cr16_pkg::DATA_W;
	localparam int AW = $clog2(DMEM_WORDS);

	cr16_pkg::decoded_t dec;
	cr16_pkg::flags_t alu_flags;
	logic [W-1:0] rd_val;
	logic [W-1:0] rs_val;
	logic [W-1:0] op_b;
	logic [W-1:0] alu_res;
	logic [W-1:0] rf_wdata;
	logic [W-1:0] dm_rdata;
	logic [AW-1:0] dm_addr;
	logic [W-1:0] ret_data;
	logic [W-1:0] ret_addr;
	logic is_cmp;
	logic rf_we;
	logic dm_we;

	instr_decoder instr_decoder_i (
		.instr (instr),
		.dec   (dec)
	);

	reg_file reg_file_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (rf_we),
		.waddr (dec.rd),
		.wdata (rf_wdata),
		.ra_a  (dec.rd),
		.ra_b  (dec.rs),
		.rd_a  (rd_val),
		.rd_b  (rs_val)
	);

	assign op_b = dec.use_imm ? dec.imm : rs_val;

	alu alu_i (
		.op     (dec.alu_op),
		.a      (rd_val),
		.b      (op_b),
		.result (alu_res),
		.flags  (alu_flags)
	);

	// word address is the source register modulo the memory depth
	assign dm_addr = AW'(rs_val % DMEM_WORDS);

	data_mem #(
		.DMEM_WORDS (DMEM_WORDS)
	) data_mem_i (
		.clk   (clk),
		.rst_n (rst_n),
		.we    (dm_we),
		.addr  (dm_addr),
		.wdata (rd_val),
		.rdata (dm_rdata)
	);

	assign is_cmp = (dec.kind == cr16_pkg::kind_alu) && (dec.alu_op == cr16_pkg::alu_cmp);
	assign rf_we = instr_valid &&
		(((dec.kind == cr16_pkg::kind_alu) && !is_cmp) || (dec.kind == cr16_pkg::kind_load));
	assign dm_we = instr_valid && (dec.kind == cr16_pkg::kind_store);
	assign rf_wdata = (dec.kind == cr16_pkg::kind_load) ? dm_rdata : alu_res;

	always_comb
	begin
		ret_addr = '0;
		case (dec.kind)
			cr16_pkg::kind_alu: ret_data = alu_res;
			cr16_pkg::kind_load: ret_data = dm_rdata;
			cr16_pkg::kind_store: ret_data = rd_val;
			default: ret_data = '0;
		endcase
		if ((dec.kind == cr16_pkg::kind_load) || (dec.kind == cr16_pkg::kind_store))
			ret_addr[AW-1:0] = dm_addr;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			flags <= '0;
		else if (instr_valid && is_cmp)
			flags <= alu_flags;
	end

	// one-cycle retire pulse, payload held between instructions
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ret <= '0;
		end
		else
		begin
			ret.valid <= instr_valid;
			if (instr_valid)
			begin
				ret.kind <= dec.kind;
				ret.rd <= dec.rd;
				ret.data <= ret_data;
				ret.addr <= ret_addr;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb/cpu_core_assert.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core_assert (
	input wire clk,
	input wire rst_n,
	input wire instr_valid,
	input wire is_cmp,
	input wire cr16_pkg::retire_t ret,
	input wire cr16_pkg::flags_t flags
);

	int fails = 0;

	assert property (@(posedge clk) !rst_n |=> !ret.valid)
	else
	begin
		$error("retire valid high right after reset");
		fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n) ret.valid |-> $past(instr_valid))
	else
	begin
		$error("retire valid without an instruction one cycle earlier");
		fails++;
	end

	assert property (@(posedge clk)
		ret.valid && (ret.kind == cr16_pkg::kind_illegal) |-> (ret.data == '0))
	else
	begin
		$error("illegal retire carries nonzero data");
		fails++;
	end

	// flags only move on the edge that commits a cmp
	assert property (@(posedge clk) disable iff (!rst_n)
		!(instr_valid && is_cmp) |=> $stable(flags))
	else
	begin
		$error("flags changed without a valid cmp");
		fails++;
	end

endmodule

bind cpu_core cpu_core_assert cpu_core_assert_i (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.is_cmp      (is_cmp),
	.ret         (ret),
	.flags       (flags)
);

`default_nettype wire

// File: tb/tb_cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;

	localparam int DMEM_WORDS = 64;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int N_INSTR = 2000;
	localparam int TIMEOUT_NS = (2 * N_INSTR + RESET_CYCLES + 200) * CLK_PERIOD;
	// register forms as {instr[15:12], instr[7:4]}
	localparam logic [7:0] REG_OPS [12] = '{8'h01, 8'h02, 8'h03, 8'h05, 8'h09, 8'h0b,
		8'h0d, 8'h0e, 8'h84, 8'h86, 8'h40, 8'h44};
	localparam logic [3:0] IMM_OPS [8] = '{4'h1, 4'h2, 4'h3, 4'h5, 4'h9, 4'hb, 4'hd, 4'he};

	logic clk = 1'b0;
	logic rst_n;
	logic instr_valid;
	logic [15:0] instr;
	cr16_pkg::retire_t ret;
	cr16_pkg::flags_t flags;

	logic [15:0] m_regs [16];
	logic [15:0] m_mem [DMEM_WORDS];
	cr16_pkg::flags_t m_flags;
	cr16_pkg::retire_t expected;
	logic pending;
	logic [31:0] rng;
	int errors;
	int sent;

	cpu_core #(
		.DMEM_WORDS (DMEM_WORDS)
	) cpu_core_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ret         (ret),
		.flags       (flags)
	);

	initial
	begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(TIMEOUT_NS);
		$display("watchdog expired, the run did not finish within %0d ns", TIMEOUT_NS);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// weighted mix, load/store boosted, lshi/lui and raw bits for illegal ones
	function automatic logic [15:0] random_instr(input logic [31:0] r);
		logic [7:0] op;
		op = REG_OPS[r[27:24] % 12];
		if (r[31:28] < 6)
			return {op[7:4], r[11:8], op[3:0], r[3:0]};
		if (r[31:28] < 8)
			return {4'h4, r[11:8], r[20] ? 4'h4 : 4'h0, r[3:0]};
		if (r[31:28] < 12)
			return {IMM_OPS[r[26:24]], r[11:0]};
		if (r[31:28] < 14)
			return r[21] ? {4'h8, r[11:8], 4'h0, r[3:0]} : {4'hf, r[11:0]};
		return r[15:0];
	endfunction

	task automatic check_value(input string field, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("** Error at %0t: %s is %h, expected %h", $time, field, got, want);
			errors++;
		end
	endtask

	// reference model, gives the expected retire and commits the instruction
	task automatic model_step(input logic [15:0] ins, output cr16_pkg::retire_t exp);
		int sel;
		int sh;
		int addr;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [31:0] wide;
		casez ({ins[15:12], ins[7:4]})
			8'h01, 8'h1?: sel = 1;
			8'h02, 8'h2?: sel = 2;
			8'h03, 8'h3?: sel = 3;
			8'h05, 8'h5?: sel = 4;
			8'h09, 8'h9?: sel = 5;
			8'h0b, 8'hb?: sel = 6;
			8'h0d, 8'hd?: sel = 7;
			8'h0e, 8'he?: sel = 8;
			8'h84: sel = 9;
			8'h86: sel = 10;
			8'h40: sel = 11;
			8'h44: sel = 12;
			default: sel = 0;
		endcase
		a = m_regs[ins[11:8]];
		b = m_regs[ins[3:0]];
		addr = b % DMEM_WORDS;
		// addi, subi, cmpi and muli sign extend, the others zero extend
		if ((ins[15:12] != 4'h0) && (sel >= 1) && (sel <= 8))
			b = (sel inside {4, 5, 6, 8}) ? {{8{ins[7]}}, ins[7:0]} : {8'h00, ins[7:0]};
		sh = $signed(b[4:0]);
		wide = {{16{a[15] && (sel == 10)}}, a};
		case (sel)
			1: res = a & b;
			2: res = a | b;
			3: res = a ^ b;
			4: res = a + b;
			5: res = a - b;
			7: res = b;
			8: res = a * b;
			9, 10: res = (sh >= 0) ? (a << sh) : 16'(wide >> (-sh));
			11: res = m_mem[addr];
			6, 12: res = a;
			default: res = '0;
		endcase
		exp = '0;
		exp.valid = 1'b1;
		exp.rd = ins[11:8];
		exp.data = res;
		if (sel == 0)
			exp.kind = cr16_pkg::kind_illegal;
		else if (sel == 11)
			exp.kind = cr16_pkg::kind_load;
		else if (sel == 12)
			exp.kind = cr16_pkg::kind_store;
		else
			exp.kind = cr16_pkg::kind_alu;
		if (sel >= 11)
			exp.addr = 16'(addr);
		if (sel == 6)
		begin
			m_flags.z = (a == b);
			m_flags.l = (a < b);
			m_flags.n = ($signed(a) < $signed(b));
		end
		if (sel == 12)
			m_mem[addr] = a;
		else if ((sel != 0) && (sel != 6))
			m_regs[ins[11:8]] = res;
	endtask

	task automatic check_outputs();
		if (pending && !ret.valid)
		begin
			$display("missing retire at %0t for an issued instruction", $time);
			errors++;
		end
		else if (!pending && ret.valid)
		begin
			$display("retire at %0t with no instruction issued", $time);
			errors++;
		end
		else if (pending)
		begin
			check_value("kind", ret.kind, expected.kind);
			check_value("rd", ret.rd, expected.rd);
			check_value("data", ret.data, expected.data);
			check_value("addr", ret.addr, expected.addr);
		end
		check_value("flags", flags, m_flags);
	endtask

	// one cycle: check the previous retire, then drive the next instruction
	task automatic issue(input logic valid, input logic [15:0] ins);
		@(negedge clk);
		check_outputs();
		instr_valid = valid;
		instr = ins;
		pending = valid;
		if (valid)
		begin
			model_step(ins, expected);
			sent++;
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		pending = 1'b0;
		m_flags = '0;
		rng = 32'h9812;
		errors = 0;
		sent = 0;
		for (int i = 0; i < 16; i++)
			m_regs[i] = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			m_mem[i] = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		// mov of every register out of reset
		for (int i = 0; i < 16; i++)
			issue(1'b1, {4'h0, 4'(i), 4'hd, 4'(i)});
		// addi r3 chain then add r4, r3 twice, every cycle
		for (int i = 0; i < 6; i++)
			issue(1'b1, 16'h5305);
		issue(1'b1, 16'h0453);
		issue(1'b1, 16'h0453);
		while (sent < N_INSTR)
		begin
			rng = xorshift(rng);
			issue(rng[17:16] != 2'b00, random_instr(rng));
		end
		issue(1'b0, '0);
		issue(1'b0, '0);
		errors += cpu_core_i.cpu_core_assert_i.fails;
		$display("run done: %0d instructions, %0d errors", sent, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
verilog/cr16_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/data_mem.sv
verilog/cpu_core.sv
tb/cpu_core_assert.sv
tb/tb_cpu_core.sv
